// ==== logic/sdctrl_pkg.sv ====
`default_nettype none

package sdctrl_pkg;

    // CRC register widths
    localparam int CRC16_W = 16;    // One per DAT lane, x^16 + x^12 + x^5 + 1
    localparam int CRC7_W  = 7;     // CMD line, x^7 + x^3 + 1

    // Short response layout, MSB first on the wire
    // Start bit, transmission bit, index, argument, CRC7, end bit
    localparam int RSP_INDEX_W  = 6;    // Command index echoed by the card
    localparam int RSP_ARG_W    = 32;   // Card status or argument field
    localparam int RSP_LEN      = 48;   // Total bits incl. start and end bit

    // CRC7 covers start, transmission, index and argument bits
    localparam int RSP_CRC_SPAN = 40;

    // Data block length used when the top level does not override it
    localparam int DEF_BLOCK_BYTES = 512;

endpackage : sdctrl_pkg

`default_nettype wire

// ==== logic/sdctrl_crc16.sv ====
`default_nettype none

// Serial CRC16 for a single DAT lane
// Polynomial x^16 + x^12 + x^5 + 1, zero seed
module sdctrl_crc16 (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_clear,    // Reload zero
    input  logic                           i_next,     // Shift one bit in
    input  logic                           i_dat,      // Serial lane bit
    output logic [sdctrl_pkg::CRC16_W-1:0] o_crc16     // Current remainder
);

    logic [sdctrl_pkg::CRC16_W-1:0] crc_q;
    logic [sdctrl_pkg::CRC16_W-1:0] crc_shift;
    logic                           fb;

    assign fb = crc_q[sdctrl_pkg::CRC16_W-1] ^ i_dat;    // Feedback term

    // Plain shift with feedback folded into the tap positions
    always_comb begin
        crc_shift     = {crc_q[sdctrl_pkg::CRC16_W-2:0], 1'b0};
        crc_shift[12] = crc_q[11] ^ fb;
        crc_shift[5]  = crc_q[4] ^ fb;
        crc_shift[0]  = fb;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin     // Clear wins over next
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_shift;
        end
    end

    assign o_crc16 = crc_q;

endmodule : sdctrl_crc16

`default_nettype wire

// ==== logic/sdctrl_crc7.sv ====
`default_nettype none

// Serial CRC7 for the CMD line
// Polynomial x^7 + x^3 + 1, zero seed
module sdctrl_crc7 (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_clear,     // Reload zero
    input  logic                          i_next,      // Shift one bit in
    input  logic                          i_dat,       // Serial CMD bit
    output logic [sdctrl_pkg::CRC7_W-1:0] o_crc7       // Current remainder
);

    logic [sdctrl_pkg::CRC7_W-1:0] crc_q;
    logic [sdctrl_pkg::CRC7_W-1:0] crc_shift;
    logic                          fb;

    // Top bit leaves the register and meets the incoming bit
    assign fb = crc_q[sdctrl_pkg::CRC7_W-1] ^ i_dat;

    always_comb begin
        crc_shift    = {crc_q[sdctrl_pkg::CRC7_W-2:0], 1'b0};
        crc_shift[3] = crc_q[2] ^ fb;   // x^3 tap
        crc_shift[0] = fb;              // x^0 tap
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_shift;
        end
    end

    assign o_crc7 = crc_q;

endmodule : sdctrl_crc7

`default_nettype wire

// ==== logic/sdctrl_dat_rx.sv ====
`default_nettype none

// 4-bit wide data block receiver
// Start bit, payload nibbles (high first), 16 CRC bits per lane, end bit
module sdctrl_dat_rx #(
    parameter int BLOCK_BYTES = sdctrl_pkg::DEF_BLOCK_BYTES
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_sample,       // One pulse per SD clock rising edge
    input  logic [3:0] i_dat,          // DAT[3:0]
    output logic [7:0] o_byte,         // Assembled byte
    output logic       o_byte_valid,   // Byte strobe
    output logic       o_blk_done,     // Block finished strobe
    output logic [3:0] o_crc_err,      // Per lane CRC mismatch
    output logic       o_end_err       // Some lane low at end bit
);

    localparam int NIBBLES = 2 * BLOCK_BYTES;
    localparam int NIB_W   = (NIBBLES > 1) ? $clog2(NIBBLES) : 1;
    localparam logic [NIB_W-1:0] NIB_LAST = NIB_W'(NIBBLES - 1);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_PAYLOAD = 2'd1;
    localparam logic [1:0] ST_CRC     = 2'd2;
    localparam logic [1:0] ST_END     = 2'd3;

    logic [1:0]                     state;
    logic [NIB_W-1:0]               nib_cnt;    // Payload nibble index
    logic [3:0]                     crc_cnt;    // CRC bit index over 16 bits
    logic [3:0]                     hi_nib;     // Upper half of current byte
    logic                           start_seen;
    logic [3:0]                     crc_clear;
    logic [3:0]                     crc_next;
    logic [sdctrl_pkg::CRC16_W-1:0] crc_val [4];    // Computed per lane
    logic [sdctrl_pkg::CRC16_W-1:0] crc_cap [4];    // Received per lane

    // Start bit is all four lanes low while idle
    assign start_seen = i_sample && (state == ST_IDLE) && (i_dat == 4'h0);

    assign crc_clear = {4{start_seen}};
    assign crc_next  = {4{i_sample && (state == ST_PAYLOAD)}};  // Payload only

    for (genvar g = 0; g < 4; g++) begin : g_lane
        sdctrl_crc16 u_crc16 (
            .i_clk   (i_clk),
            .i_nrst  (i_nrst),
            .i_clear (crc_clear[g]),
            .i_next  (crc_next[g]),
            .i_dat   (i_dat[g]),
            .o_crc16 (crc_val[g])
        );
    end

    // Byte assembly and received CRC capture
    always_ff @(posedge i_clk) begin
        if (i_sample && (state == ST_PAYLOAD)) begin
            if (!nib_cnt[0]) begin
                hi_nib <= i_dat;                // Even index is the high nibble
            end else begin
                o_byte <= {hi_nib, i_dat};
            end
        end
        if (i_sample && (state == ST_CRC)) begin
            // Received CRC arrives MSB first on every lane
            for (int l = 0; l < 4; l++) begin
                crc_cap[l] <= {crc_cap[l][sdctrl_pkg::CRC16_W-2:0], i_dat[l]};
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= ST_IDLE;
            nib_cnt      <= '0;
            crc_cnt      <= '0;
            o_byte_valid <= 1'b0;
            o_blk_done   <= 1'b0;
            o_crc_err    <= '0;
            o_end_err    <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;       // Strobes last one cycle
            o_blk_done   <= 1'b0;
            if (i_sample) begin
                case (state)
                    ST_IDLE: begin
                        if (start_seen) begin
                            state   <= ST_PAYLOAD;
                            nib_cnt <= '0;
                        end
                    end
                    ST_PAYLOAD: begin
                        o_byte_valid <= nib_cnt[0];     // Low nibble completes a byte
                        if (nib_cnt == NIB_LAST) begin
                            state   <= ST_CRC;
                            crc_cnt <= '0;
                        end else begin
                            nib_cnt <= nib_cnt + 1'b1;
                        end
                    end
                    ST_CRC: begin
                        if (crc_cnt == 4'hF) begin
                            state <= ST_END;
                        end
                        crc_cnt <= crc_cnt + 1'b1;
                    end
                    default: begin
                        // End bit sample with the CRC registers frozen
                        o_blk_done <= 1'b1;
                        o_end_err  <= (i_dat != 4'hF);
                        for (int l = 0; l < 4; l++) begin
                            o_crc_err[l] <= (crc_cap[l] != crc_val[l]);
                        end
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule : sdctrl_dat_rx

`default_nettype wire

// ==== logic/sdctrl_cmd_rx.sv ====
`default_nettype none

// Short (48-bit) command response receiver on CMD
module sdctrl_cmd_rx (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_sample,       // SD clock edge strobe
    input  logic                               i_cmd,          // CMD line
    output logic                               o_rsp_valid,    // Response strobe
    output logic [sdctrl_pkg::RSP_INDEX_W-1:0] o_rsp_index,
    output logic [sdctrl_pkg::RSP_ARG_W-1:0]   o_rsp_arg,
    output logic                               o_rsp_crc_err,  // CRC7 mismatch
    output logic                               o_rsp_end_err   // End bit low
);

    localparam int CNT_W = $clog2(sdctrl_pkg::RSP_LEN);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(sdctrl_pkg::RSP_LEN - 1);
    localparam logic [CNT_W-1:0] CRC_SPAN = CNT_W'(sdctrl_pkg::RSP_CRC_SPAN);

    // Field positions inside the full response word
    localparam int ARG_LSB = sdctrl_pkg::CRC7_W + 1;
    localparam int IDX_LSB = ARG_LSB + sdctrl_pkg::RSP_ARG_W;

    logic                             busy;       // Receiving a response
    logic [CNT_W-1:0]                 bit_cnt;    // Bit index, start bit is 0
    logic [sdctrl_pkg::RSP_LEN-1:0]   rsp_sreg;   // Shifted in MSB first
    logic                             start_seen;
    logic                             crc_next;
    logic [sdctrl_pkg::CRC7_W-1:0]    crc_val;

    assign start_seen = i_sample && !busy && !i_cmd;
    // Bits 1..39, start bit handled by the clear
    assign crc_next   = i_sample && busy && (bit_cnt < CRC_SPAN);

    sdctrl_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (start_seen),
        .i_next  (crc_next),
        .i_dat   (i_cmd),
        .o_crc7  (crc_val)
    );

    always_ff @(posedge i_clk) begin
        if (start_seen || (i_sample && busy)) begin
            rsp_sreg <= {rsp_sreg[sdctrl_pkg::RSP_LEN-2:0], i_cmd};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy          <= 1'b0;
            bit_cnt       <= '0;
            o_rsp_valid   <= 1'b0;
            o_rsp_crc_err <= 1'b0;
            o_rsp_end_err <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            if (start_seen) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (i_sample && busy) begin
                if (bit_cnt == BIT_LAST) begin
                    busy          <= 1'b0;
                    o_rsp_valid   <= 1'b1;
                    // Received CRC still sits in the low bits before this shift
                    o_rsp_crc_err <= (rsp_sreg[sdctrl_pkg::CRC7_W-1:0] != crc_val);
                    o_rsp_end_err <= !i_cmd;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Full word is in place the cycle the strobe fires
    assign o_rsp_index = rsp_sreg[IDX_LSB +: sdctrl_pkg::RSP_INDEX_W];
    assign o_rsp_arg   = rsp_sreg[ARG_LSB +: sdctrl_pkg::RSP_ARG_W];

endmodule : sdctrl_cmd_rx

`default_nettype wire

// ==== logic/sdctrl_rx_top.sv ====
`default_nettype none

// Receive side of the SD bus, data block and short response in parallel
module sdctrl_rx_top #(
    parameter int BLOCK_BYTES = sdctrl_pkg::DEF_BLOCK_BYTES    // Data block size
) (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_sample,       // Sample strobe
    input  logic [3:0]                         i_dat,          // DAT lanes
    input  logic                               i_cmd,          // CMD line

    // Data block receiver
    output logic [7:0]                         o_byte,
    output logic                               o_byte_valid,
    output logic                               o_blk_done,
    output logic [3:0]                         o_crc_err,
    output logic                               o_end_err,

    // Command response receiver
    output logic                               o_rsp_valid,
    output logic [sdctrl_pkg::RSP_INDEX_W-1:0] o_rsp_index,
    output logic [sdctrl_pkg::RSP_ARG_W-1:0]   o_rsp_arg,
    output logic                               o_rsp_crc_err,
    output logic                               o_rsp_end_err
);

    sdctrl_dat_rx #(
        .BLOCK_BYTES (BLOCK_BYTES)
    ) u_dat_rx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_sample     (i_sample),
        .i_dat        (i_dat),
        .o_byte       (o_byte),
        .o_byte_valid (o_byte_valid),
        .o_blk_done   (o_blk_done),
        .o_crc_err    (o_crc_err),
        .o_end_err    (o_end_err)
    );

    // Shares only the sample strobe with the data path
    sdctrl_cmd_rx u_cmd_rx (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_sample      (i_sample),
        .i_cmd         (i_cmd),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp_index   (o_rsp_index),
        .o_rsp_arg     (o_rsp_arg),
        .o_rsp_crc_err (o_rsp_crc_err),
        .o_rsp_end_err (o_rsp_end_err)
    );

endmodule : sdctrl_rx_top

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`default_nettype none

// Free running clock and power-on reset for the testbench
module tb_clk_gen #(
    parameter int CLK_NS     = 8,   // Clock period
    parameter int RST_CYCLES = 8    // Cycles with reset held low
) (
    output logic o_clk,
    output logic o_nrst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(CLK_NS / 2.0) o_clk = ~o_clk;
    end

    initial begin
        o_nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);   // Release away from the active edge
        o_nrst = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/sdctrl_rx_properties.sv ====
`default_nettype none

// Strobe and reset rules of the receive top level
module sdctrl_rx_properties (
    input logic i_clk,
    input logic i_nrst,
    input logic i_sample,
    input logic i_byte_valid,
    input logic i_blk_done,
    input logic i_rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // Assertion failures so far

    // Nothing may fire while reset is held
    a_quiet_in_reset: assert property (@(posedge i_clk)
        !i_nrst |-> !i_byte_valid && !i_blk_done && !i_rsp_valid)
        else begin
            $error("Strobe active during reset");
            fail_cnt++;
        end

    a_blk_done_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_blk_done |=> !i_blk_done)
        else begin
            $error("o_blk_done high for two cycles");
            fail_cnt++;
        end

    a_rsp_valid_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp_valid |=> !i_rsp_valid)
        else begin
            $error("o_rsp_valid high for two cycles");
            fail_cnt++;
        end

    // A byte can only complete on a sample
    a_byte_after_sample: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_byte_valid |-> $past(i_sample))
        else begin
            $error("o_byte_valid without a sample in the cycle before");
            fail_cnt++;
        end

endmodule : sdctrl_rx_properties

`default_nettype wire

// ==== verif/tb_sdctrl_checker.sv ====
`default_nettype none

// Watches the DUT outputs and compares them with what the top expects
module tb_sdctrl_checker #(
    parameter int BLOCK_BYTES = 8
) (
    input logic                               i_clk,
    input logic                               i_nrst,
    input logic [7:0]                         i_byte,
    input logic                               i_byte_valid,
    input logic                               i_blk_done,
    input logic [3:0]                         i_crc_err,
    input logic                               i_end_err,
    input logic                               i_rsp_valid,
    input logic [sdctrl_pkg::RSP_INDEX_W-1:0] i_rsp_index,
    input logic [sdctrl_pkg::RSP_ARG_W-1:0]   i_rsp_arg,
    input logic                               i_rsp_crc_err,
    input logic                               i_rsp_end_err
);
    timeunit 1ns;
    timeprecision 1ps;

    string                              row_name = "none";
    logic [7:0]                         exp_bytes [$];  // Payload still to come
    logic [3:0]                         exp_crc_err;
    logic                               exp_end_err;
    logic [sdctrl_pkg::RSP_INDEX_W-1:0] exp_index;
    logic [sdctrl_pkg::RSP_ARG_W-1:0]   exp_arg;
    logic                               exp_rsp_crc_err;
    int                                 byte_cnt;
    bit                                 blk_seen;
    bit                                 rsp_seen;
    int                                 err_cnt = 0;
    int                                 chk_cnt = 0;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", row_name, what, exp, act);
        end
    endtask

    // Hand-off from the top, once per row before any sample goes out
    task automatic start_row(input string name, input logic [3:0] crc_mask,
                             input logic end_bad, input logic [5:0] index,
                             input logic [31:0] arg, input logic rsp_crc_bad);
        row_name        = name;
        exp_bytes.delete();
        exp_crc_err     = crc_mask;
        exp_end_err     = end_bad;
        exp_index       = index;
        exp_arg         = arg;
        exp_rsp_crc_err = rsp_crc_bad;
        byte_cnt        = 0;
        blk_seen        = 1'b0;
        rsp_seen        = 1'b0;
    endtask

    task automatic push_byte(input logic [7:0] value);
        exp_bytes.push_back(value);
    endtask

    function automatic bit row_complete();
        return blk_seen && rsp_seen;
    endfunction

    task automatic close_row();
        if (!blk_seen) begin
            err_cnt++;
            $display("Test %s: the block never finished, no o_blk_done pulse", row_name);
        end
        if (!rsp_seen) begin
            err_cnt++;
            $display("Test %s: the response never arrived, no o_rsp_valid pulse", row_name);
        end
        check_value("byte count", 32'(BLOCK_BYTES), 32'(byte_cnt));
    endtask

    function automatic int error_count();
        return err_cnt;
    endfunction

    function automatic int check_count();
        return chk_cnt;
    endfunction

    // Registered outputs are steady at the falling edge
    always @(negedge i_clk) begin
        if (i_nrst) begin
            if (i_byte_valid) begin
                if (exp_bytes.size() == 0) begin
                    err_cnt++;
                    $display("Test %s: got a byte beyond the end of the block", row_name);
                end else begin
                    check_value($sformatf("byte %0d", byte_cnt),
                                32'(exp_bytes.pop_front()), 32'(i_byte));
                end
                byte_cnt++;
            end
            if (i_blk_done) begin
                blk_seen = 1'b1;
                check_value("o_crc_err", 32'(exp_crc_err), 32'(i_crc_err));
                check_value("o_end_err", 32'(exp_end_err), 32'(i_end_err));
            end
            if (i_rsp_valid) begin
                rsp_seen = 1'b1;
                check_value("o_rsp_index", 32'(exp_index), 32'(i_rsp_index));
                check_value("o_rsp_arg", exp_arg, i_rsp_arg);
                check_value("o_rsp_crc_err", 32'(exp_rsp_crc_err), 32'(i_rsp_crc_err));
                check_value("o_rsp_end_err", 32'(0), 32'(i_rsp_end_err));   // Always sent high
            end
        end
    end

endmodule : tb_sdctrl_checker

`default_nettype wire

// ==== verif/tb_sdctrl_rx.sv ====
`default_nettype none

// Testbench top for the SD receive path
module tb_sdctrl_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLOCK_BYTES = 8;
    localparam int CLK_NS      = 8;
    localparam int RST_CYCLES  = 8;
    localparam int NUM_ROWS    = 7;
    localparam int MAX_SPACING = 3;
    localparam int BLK_SAMPLES = 2 * BLOCK_BYTES + sdctrl_pkg::CRC16_W + 2;    // Start and end
    localparam int RSP_OFFSET  = 4;     // Response starts inside the payload
    localparam int NUM_SLOTS   = RSP_OFFSET + sdctrl_pkg::RSP_LEN + 2;
    localparam int WAIT_LIMIT  = 16 * MAX_SPACING;
    localparam int WATCHDOG_NS = NUM_ROWS * (BLK_SAMPLES + sdctrl_pkg::RSP_LEN)
                                 * MAX_SPACING * CLK_NS * 2 + RST_CYCLES * CLK_NS;

    typedef struct {
        string       name;
        logic [31:0] seed;          // Mixed into the random payload
        logic [3:0]  crc_mask;      // Lanes whose CRC gets a flipped bit
        logic        end_bad;       // Lane 0 low at the end bit
        logic [5:0]  index;
        logic [31:0] arg;
        logic        rsp_crc_bad;
        int          spacing;       // Clocks per sample strobe
    } row_t;

    row_t rows [NUM_ROWS];
    int   n_rows = 0;

    logic        clk;
    logic        nrst;
    logic        sample;
    logic [3:0]  dat;
    logic        cmd;
    logic [7:0]  byte_out;
    logic        byte_valid;
    logic        blk_done;
    logic [3:0]  crc_err;
    logic        end_err;
    logic        rsp_valid;
    logic [5:0]  rsp_index;
    logic [31:0] rsp_arg;
    logic        rsp_crc_err;
    logic        rsp_end_err;

    tb_clk_gen #(.CLK_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    sdctrl_rx_top #(.BLOCK_BYTES(BLOCK_BYTES)) i_dut (
        .i_clk (clk), .i_nrst (nrst), .i_sample (sample), .i_dat (dat), .i_cmd (cmd),
        .o_byte (byte_out), .o_byte_valid (byte_valid), .o_blk_done (blk_done),
        .o_crc_err (crc_err), .o_end_err (end_err), .o_rsp_valid (rsp_valid),
        .o_rsp_index (rsp_index), .o_rsp_arg (rsp_arg),
        .o_rsp_crc_err (rsp_crc_err), .o_rsp_end_err (rsp_end_err)
    );

    tb_sdctrl_checker #(.BLOCK_BYTES(BLOCK_BYTES)) u_checker (
        .i_clk (clk), .i_nrst (nrst), .i_byte (byte_out), .i_byte_valid (byte_valid),
        .i_blk_done (blk_done), .i_crc_err (crc_err), .i_end_err (end_err),
        .i_rsp_valid (rsp_valid), .i_rsp_index (rsp_index), .i_rsp_arg (rsp_arg),
        .i_rsp_crc_err (rsp_crc_err), .i_rsp_end_err (rsp_end_err)
    );

    bind sdctrl_rx_top sdctrl_rx_properties u_props (
        .i_clk (i_clk), .i_nrst (i_nrst), .i_sample (i_sample),
        .i_byte_valid (o_byte_valid), .i_blk_done (o_blk_done), .i_rsp_valid (o_rsp_valid)
    );

    // Long division by x^16 + x^12 + x^5 + 1, one bit per call
    function automatic logic [15:0] crc16_shift(input logic [15:0] crc, input logic b);
        return {crc[14:0], 1'b0} ^ ((crc[15] ^ b) ? 16'h1021 : 16'h0000);
    endfunction

    function automatic logic [6:0] crc7_shift(input logic [6:0] crc, input logic b);
        return {crc[5:0], 1'b0} ^ ((crc[6] ^ b) ? 7'h09 : 7'h00);   // x^7 + x^3 + 1
    endfunction

    task automatic add_row(input string name, input logic [31:0] seed,
                           input logic [3:0] crc_mask, input logic end_bad,
                           input logic [5:0] index, input logic [31:0] arg,
                           input logic rsp_crc_bad, input int spacing);
        rows[n_rows] = '{name, seed, crc_mask, end_bad, index, arg, rsp_crc_bad, spacing};
        n_rows++;
    endtask

    // One sample strobe, then idle clocks up to the row's spacing
    task automatic send_slot(input logic [3:0] d, input logic c, input int spacing);
        @(negedge clk);
        sample = 1'b1;
        dat    = d;
        cmd    = c;
        for (int s = 1; s < spacing; s++) begin
            @(negedge clk);
            sample = 1'b0;
        end
    endtask

    task automatic run_row(input row_t row);
        logic [7:0]  payload [BLOCK_BYTES];
        logic [15:0] lane_crc [4];
        logic [3:0]  dat_slot [NUM_SLOTS];
        logic        cmd_slot [NUM_SLOTS];
        logic [3:0]  nib;
        logic [47:0] rsp_word;
        logic [6:0]  rsp_crc;
        int          waited;
        u_checker.start_row(row.name, row.crc_mask, row.end_bad, row.index, row.arg,
                            row.rsp_crc_bad);
        for (int k = 0; k < NUM_SLOTS; k++) begin
            dat_slot[k] = 4'hF;     // Bus idles high
            cmd_slot[k] = 1'b1;
        end
        for (int l = 0; l < 4; l++) lane_crc[l] = '0;
        dat_slot[0] = 4'h0;         // Start bit on every lane
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            payload[b] = 8'($urandom) ^ row.seed[8 * (b % 4) +: 8];
            u_checker.push_byte(payload[b]);
            for (int h = 0; h < 2; h++) begin
                nib = (h == 0) ? payload[b][7:4] : payload[b][3:0];    // High nibble first
                dat_slot[1 + 2 * b + h] = nib;
                for (int l = 0; l < 4; l++) lane_crc[l] = crc16_shift(lane_crc[l], nib[l]);
            end
        end
        for (int l = 0; l < 4; l++) begin
            if (row.crc_mask[l]) lane_crc[l] = lane_crc[l] ^ 16'h0040;
            for (int i = 0; i < 16; i++) dat_slot[1 + 2 * BLOCK_BYTES + i][l] = lane_crc[l][15 - i];
        end
        dat_slot[BLK_SAMPLES - 1] = row.end_bad ? 4'hE : 4'hF;
        // Start and transmission bits are both zero for a card response
        rsp_word = {2'b00, row.index, row.arg, 8'h00};
        rsp_crc  = '0;
        for (int k = 47; k >= 8; k--) rsp_crc = crc7_shift(rsp_crc, rsp_word[k]);
        rsp_word[7:0] = {rsp_crc ^ {6'd0, row.rsp_crc_bad}, 1'b1};
        for (int k = 0; k < sdctrl_pkg::RSP_LEN; k++) cmd_slot[RSP_OFFSET + k] = rsp_word[47 - k];
        for (int k = 0; k < NUM_SLOTS; k++) send_slot(dat_slot[k], cmd_slot[k], row.spacing);
        @(negedge clk);
        sample = 1'b0;
        waited = 0;
        while (!u_checker.row_complete() && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        u_checker.close_row();
        repeat (3) @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int total_err;
        sample = 1'b0;
        dat    = 4'hF;
        cmd    = 1'b1;
        void'($urandom(32'h7c30ee63));
        //      name            seed          crc   end   idx    arg           crc7  gap
        add_row("clean_block",  32'h00000000, 4'h0, 1'b0, 6'd17, 32'h00000900, 1'b0, 1);
        add_row("crc_lane_0_3", 32'h12345678, 4'h9, 1'b0, 6'd18, 32'hdeadbeef, 1'b0, 2);
        add_row("crc_all",      32'ha5a55a5a, 4'hF, 1'b0, 6'd3,  32'h12340000, 1'b1, 3);
        add_row("end_bit",      32'h0f0f0f0f, 4'h0, 1'b1, 6'd7,  32'h00000700, 1'b0, 1);
        add_row("end_and_crc1", 32'hffffffff, 4'h2, 1'b1, 6'd55, 32'h80000001, 1'b1, 2);
        add_row("rsp_crc_bad",  32'h3c3c3c3c, 4'h0, 1'b0, 6'd13, 32'hffffffff, 1'b1, 3);
        add_row("overlap_zero", 32'h00ff00ff, 4'h4, 1'b0, 6'd0,  32'h00000000, 1'b0, 2);
        wait (nrst === 1'b1);
        repeat (2) @(negedge clk);
        for (int r = 0; r < n_rows; r++) run_row(rows[r]);
        total_err = u_checker.error_count() + i_dut.u_props.fail_cnt;
        $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 n_rows, u_checker.check_count(), u_checker.error_count(),
                 i_dut.u_props.fail_cnt);
        if (total_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_sdctrl_rx

`default_nettype wire

// ==== flist.f ====
logic/sdctrl_pkg.sv
logic/sdctrl_crc16.sv
logic/sdctrl_crc7.sv
logic/sdctrl_dat_rx.sv
logic/sdctrl_cmd_rx.sv
logic/sdctrl_rx_top.sv
verif/tb_clk_gen.sv
verif/sdctrl_rx_properties.sv
verif/tb_sdctrl_checker.sv
verif/tb_sdctrl_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SD receive testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_sdctrl_rx -f flist.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
